// ==== Makefile ====
# Verilator build and run for the banked coefficient memory.

TOP := tb_ntt_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -Mdir obj_dir -f flist.f

# the log decides pass or fail.
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/ntt_mem_defs.svh ====
`ifndef NTT_MEM_DEFS_SVH
`define NTT_MEM_DEFS_SVH

// parallel access lanes.
`define NTT_LANES 16

// memory banks.
`define NTT_BANKS 16

// words per bank, power of two.
`define NTT_DEPTH 8

// coefficient width in bits.
`define NTT_DATA_W 16

// lanes still active in the final transform stage.
`define NTT_LAST_LANES 2

`endif

// ==== common/ntt_mem_pkg.sv ====
`include "ntt_mem_defs.svh"

package ntt_mem_pkg;

    // bank select.
    typedef logic [$clog2(`NTT_BANKS)-1:0] bank_idx_t;

    // word address inside one bank.
    typedef logic [$clog2(`NTT_DEPTH)-1:0] addr_idx_t;

    // one coefficient word.
    typedef logic [`NTT_DATA_W-1:0] coef_t;

    // one bit per lane, set for active lanes.
    typedef logic [`NTT_LANES-1:0] lane_mask_t;

    // names one storage word.
    typedef struct packed {
        bank_idx_t bank;
        addr_idx_t addr;
    } lane_loc_t;

    // per-lane locations, lane 0 in the low slot.
    typedef lane_loc_t [`NTT_LANES-1:0] loc_vec_t;

    // per-lane coefficients.
    typedef coef_t [`NTT_LANES-1:0] coef_vec_t;

endpackage

// ==== flist.f ====
+incdir+common
+incdir+tb
common/ntt_mem_pkg.sv
ntt_mem/bank_array.sv
ntt_mem/read_stage.sv
ntt_mem/ntt_mem.sv
tb/tb_ntt_mem.sv

// ==== ntt_mem/bank_array.sv ====
`timescale 1ns/10ps

`include "ntt_mem_defs.svh"

module bank_array
    import ntt_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  lane_mask_t lane_mask,
    input  logic       wr_en,
    input  loc_vec_t   wr_loc,
    input  coef_vec_t  wr_data,
    input  loc_vec_t   rd_loc,
    output coef_vec_t  mux_data
);

    // storage, bank major.
    coef_t mem [`NTT_BANKS][`NTT_DEPTH];

    // lanes that write this cycle.
    lane_mask_t wr_act;

    // per-word write enable and winning data.
    logic [`NTT_DEPTH-1:0] word_we [`NTT_BANKS];
    coef_t                 word_wd [`NTT_BANKS][`NTT_DEPTH];

    assign wr_act = {`NTT_LANES{wr_en}} & lane_mask;

    // collision resolve.
    // ascending scan, so a later lane overrides an earlier one on the same word.
    always_comb begin
        for (int b = 0; b < `NTT_BANKS; b++) begin
            word_we[b] = '0;
            for (int a = 0; a < `NTT_DEPTH; a++) begin
                word_wd[b][a] = '0;
            end
        end
        for (int l = 0; l < `NTT_LANES; l++) begin
            if (wr_act[l]) begin
                word_we[wr_loc[l].bank][wr_loc[l].addr] = 1'b1;
                word_wd[wr_loc[l].bank][wr_loc[l].addr] = wr_data[l];
            end
        end
    end

    // storage update.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int b = 0; b < `NTT_BANKS; b++) begin
                for (int a = 0; a < `NTT_DEPTH; a++) begin
                    mem[b][a] <= '0;
                end
            end
        end else begin
            for (int b = 0; b < `NTT_BANKS; b++) begin
                for (int a = 0; a < `NTT_DEPTH; a++) begin
                    if (word_we[b][a]) begin
                        mem[b][a] <= word_wd[b][a];
                    end
                end
            end
        end
    end

    // read mux, one per lane.
    // reads the array as it stands before this edge's write.
    for (genvar l = 0; l < `NTT_LANES; l++) begin : g_rd_mux
        assign mux_data[l] = mem[rd_loc[l].bank][rd_loc[l].addr];
    end

    // indices must be clean whenever a write is requested.
    a_wr_loc_known: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_loc)
    ) else $error("bank_array: unknown wr_loc with wr_en high");

    // top level mask never drops lane 0.
    a_lane0_active: assert property (
        @(posedge clk) disable iff (rst)
        lane_mask[0]
    ) else $error("bank_array: lane 0 masked off");

endmodule

// ==== ntt_mem/ntt_mem.sv ====
`timescale 1ns/10ps

`include "ntt_mem_defs.svh"

module ntt_mem
    import ntt_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      last_stage,
    input  logic      rd_en,
    input  loc_vec_t  rd_loc,
    input  logic      wr_en,
    input  loc_vec_t  wr_loc,
    input  coef_vec_t wr_data,
    output coef_vec_t rd_data,
    output loc_vec_t  rd_loc_echo,
    output logic      rd_valid,
    output logic      wr_done
);

    lane_mask_t lane_mask;
    coef_vec_t  mux_data;

    // final stage only drives the low lanes.
    assign lane_mask = last_stage ? lane_mask_t'((1 << `NTT_LAST_LANES) - 1) : '1;

    bank_array bank_array_i (
        .clk       (clk),
        .rst       (rst),
        .lane_mask (lane_mask),
        .wr_en     (wr_en),
        .wr_loc    (wr_loc),
        .wr_data   (wr_data),
        .rd_loc    (rd_loc),
        .mux_data  (mux_data)
    );

    // mux_data is pre-write, so a same-cycle read sees the old word.
    read_stage read_stage_i (
        .clk         (clk),
        .rst         (rst),
        .lane_mask   (lane_mask),
        .rd_en       (rd_en),
        .wr_en       (wr_en),
        .rd_loc      (rd_loc),
        .mux_data    (mux_data),
        .rd_data     (rd_data),
        .rd_loc_echo (rd_loc_echo),
        .rd_valid    (rd_valid),
        .wr_done     (wr_done)
    );

endmodule

// ==== ntt_mem/read_stage.sv ====
`timescale 1ns/10ps

`include "ntt_mem_defs.svh"

module read_stage
    import ntt_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  lane_mask_t lane_mask,
    input  logic       rd_en,
    input  logic       wr_en,
    input  loc_vec_t   rd_loc,
    input  coef_vec_t  mux_data,
    output coef_vec_t  rd_data,
    output loc_vec_t   rd_loc_echo,
    output logic       rd_valid,
    output logic       wr_done
);

    // next register values.
    coef_vec_t rd_data_d;
    loc_vec_t  rd_loc_d;

    // idle cycles and masked lanes load zero.
    always_comb begin
        for (int l = 0; l < `NTT_LANES; l++) begin
            if (rd_en && lane_mask[l]) begin
                rd_data_d[l] = mux_data[l];
                rd_loc_d[l]  = rd_loc[l];
            end else begin
                rd_data_d[l] = '0;
                rd_loc_d[l]  = '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data     <= '0;
            rd_loc_echo <= '0;
            rd_valid    <= 1'b0;
            wr_done     <= 1'b0;
        end else begin
            rd_data     <= rd_data_d;
            rd_loc_echo <= rd_loc_d;
            rd_valid    <= rd_en;
            // write already landed in storage at this edge.
            wr_done     <= wr_en;
        end
    end

    // no stale data leaks out between reads.
    a_idle_zero: assert property (
        @(posedge clk) disable iff (rst)
        !rd_valid |-> (rd_data == '0)
    ) else $error("read_stage: rd_data nonzero while rd_valid low");

endmodule

// ==== tb/ntt_mem_checks.svh ====
`ifndef NTT_MEM_CHECKS_SVH
`define NTT_MEM_CHECKS_SVH

// one line per wrong value, counted for the summary.
function automatic void flag_mismatch(input string what);
    err_count++;
    $display("Mismatch at %0d ns: %s", $time, what);
endfunction

// outputs stay quiet while reset is held.
a_reset_quiet: assert property (
    @(posedge clk) rst |-> (!rd_valid && !wr_done)
) else flag_mismatch("rd_valid or wr_done high during reset");

a_reset_clear: assert property (
    @(posedge clk) rst |-> (rd_data == '0 && rd_loc_echo == '0)
) else flag_mismatch("read outputs not cleared during reset");

// strobes follow the model cycle by cycle.
a_valid_model: assert property (
    @(posedge clk) disable iff (rst)
    rd_valid == exp_rd_valid
) else flag_mismatch("rd_valid differs from model");

a_done_model: assert property (
    @(posedge clk) disable iff (rst)
    wr_done == exp_wr_done
) else flag_mismatch("wr_done differs from model");

// read data, masked lanes included.
a_read_data: assert property (
    @(posedge clk) disable iff (rst)
    rd_valid |-> (rd_data == exp_rd_data)
) else flag_mismatch("rd_data differs from model");

a_read_echo: assert property (
    @(posedge clk) disable iff (rst)
    rd_valid |-> (rd_loc_echo == exp_rd_loc_echo)
) else flag_mismatch("rd_loc_echo differs from requested locations");

// idle cycles drive zero on every lane.
a_idle_zero: assert property (
    @(posedge clk) disable iff (rst)
    !rd_valid |-> (rd_data == '0 && rd_loc_echo == '0)
) else flag_mismatch("read outputs nonzero in an idle cycle");

task automatic start_test();
    errs_at_start = err_count;
endtask

// lets the last result reach the assertions, then scores the test.
task automatic finish_test(input string name);
    idle_inputs();
    step();
    step();
    test_num++;
    if (err_count == errs_at_start) begin
        tests_passed++;
        $display("test %0d %s: ok", test_num, name);
    end else begin
        tests_failed++;
        $display("test %0d %s: FAILED with %0d mismatches",
                 test_num, name, err_count - errs_at_start);
    end
endtask

`endif

// ==== tb/tb_ntt_mem.sv ====
`timescale 1ns/10ps

`include "ntt_mem_defs.svh"

module tb_ntt_mem
    import ntt_mem_pkg::*;
();

    // the sequence takes about 40 cycles.
    localparam int MAX_CYCLES = 400;
    localparam int WORDS      = `NTT_BANKS * `NTT_DEPTH;

    logic      clk;
    logic      rst;
    logic      last_stage;
    logic      rd_en;
    loc_vec_t  rd_loc;
    logic      wr_en;
    loc_vec_t  wr_loc;
    coef_vec_t wr_data;
    coef_vec_t rd_data;
    loc_vec_t  rd_loc_echo;
    logic      rd_valid;
    logic      wr_done;

    int cycle_count   = 0;
    int err_count     = 0;
    int errs_at_start = 0;
    int test_num      = 0;
    int tests_passed  = 0;
    int tests_failed  = 0;

    // reference model state.
    coef_t     ref_mem [`NTT_BANKS][`NTT_DEPTH];
    coef_vec_t exp_rd_data;
    loc_vec_t  exp_rd_loc_echo;
    logic      exp_rd_valid;
    logic      exp_wr_done;

    ntt_mem ntt_mem_i (
        .clk         (clk),
        .rst         (rst),
        .last_stage  (last_stage),
        .rd_en       (rd_en),
        .rd_loc      (rd_loc),
        .wr_en       (wr_en),
        .wr_loc      (wr_loc),
        .wr_data     (wr_data),
        .rd_data     (rd_data),
        .rd_loc_echo (rd_loc_echo),
        .rd_valid    (rd_valid),
        .wr_done     (wr_done)
    );

    `include "ntt_mem_checks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // model predicts the registered outputs.
    // reads see the old word, then writes land in lane order.
    always @(posedge clk or posedge rst) begin
        logic live;
        if (rst) begin
            for (int b = 0; b < `NTT_BANKS; b++) begin
                for (int a = 0; a < `NTT_DEPTH; a++) begin
                    ref_mem[b][a] = '0;
                end
            end
            exp_rd_data     <= '0;
            exp_rd_loc_echo <= '0;
            exp_rd_valid    <= 1'b0;
            exp_wr_done     <= 1'b0;
        end else begin
            for (int l = 0; l < `NTT_LANES; l++) begin
                live = !last_stage || (l < `NTT_LAST_LANES);
                if (rd_en && live) begin
                    exp_rd_data[l]     <= ref_mem[rd_loc[l].bank][rd_loc[l].addr];
                    exp_rd_loc_echo[l] <= rd_loc[l];
                end else begin
                    exp_rd_data[l]     <= '0;
                    exp_rd_loc_echo[l] <= '0;
                end
            end
            for (int l = 0; l < `NTT_LANES; l++) begin
                live = !last_stage || (l < `NTT_LAST_LANES);
                if (wr_en && live) begin
                    ref_mem[wr_loc[l].bank][wr_loc[l].addr] = wr_data[l];
                end
            end
            exp_rd_valid <= rd_en;
            exp_wr_done  <= wr_en;
        end
    end

    task automatic idle_inputs();
        last_stage = 1'b0;
        rd_en      = 1'b0;
        rd_loc     = '0;
        wr_en      = 1'b0;
        wr_loc     = '0;
        wr_data    = '0;
    endtask

    // inputs change 1 ns after the edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // odd stride over all words keeps the lanes distinct.
    task automatic rand_locs(output loc_vec_t locs);
        int start;
        int stride;
        int idx;
        start  = int'($urandom_range(WORDS - 1));
        stride = 2 * int'($urandom_range(WORDS / 2 - 1)) + 1;
        for (int l = 0; l < `NTT_LANES; l++) begin
            idx = (start + l * stride) % WORDS;
            locs[l].bank = bank_idx_t'(idx / `NTT_DEPTH);
            locs[l].addr = addr_idx_t'(idx % `NTT_DEPTH);
        end
    endtask

    task automatic rand_data(output coef_vec_t data);
        for (int l = 0; l < `NTT_LANES; l++) begin
            data[l] = coef_t'($urandom);
        end
    endtask

    initial begin
        loc_vec_t  locs;
        loc_vec_t  other;
        coef_vec_t data;
        void'($urandom(14105));
        idle_inputs();
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test();
        rand_locs(locs);
        rd_en  = 1'b1;
        rd_loc = locs;
        step();
        finish_test("read after reset");

        start_test();
        rand_locs(locs);
        rand_data(data);
        wr_en   = 1'b1;
        wr_loc  = locs;
        wr_data = data;
        step();
        idle_inputs();
        rd_en  = 1'b1;
        rd_loc = locs;
        step();
        finish_test("full lane write then read");

        // write and read in the final stage, normal read between.
        start_test();
        rand_locs(locs);
        rand_data(data);
        last_stage = 1'b1;
        wr_en      = 1'b1;
        wr_loc     = locs;
        wr_data    = data;
        step();
        idle_inputs();
        rd_en  = 1'b1;
        rd_loc = locs;
        step();
        last_stage = 1'b1;
        step();
        finish_test("last stage masking");

        start_test();
        rand_locs(locs);
        rand_data(data);
        rd_en   = 1'b1;
        rd_loc  = locs;
        wr_en   = 1'b1;
        wr_loc  = locs;
        wr_data = data;
        step();
        idle_inputs();
        rd_en  = 1'b1;
        rd_loc = locs;
        step();
        finish_test("read during write");

        // every lane hits one word.
        start_test();
        rand_locs(other);
        for (int l = 0; l < `NTT_LANES; l++) begin
            locs[l] = other[0];
        end
        rand_data(data);
        wr_en   = 1'b1;
        wr_loc  = locs;
        wr_data = data;
        step();
        idle_inputs();
        rd_en  = 1'b1;
        rd_loc = locs;
        step();
        finish_test("write collision");

        start_test();
        rand_locs(locs);
        rand_locs(other);
        rd_en  = 1'b1;
        rd_loc = locs;
        step();
        idle_inputs();
        step();
        rd_en  = 1'b1;
        rd_loc = other;
        step();
        rd_loc = locs;
        step();
        finish_test("idle gap and back to back reads");

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
